// ==== rtl/cp0_reg_pkg.sv ====
package cp0_reg_pkg;

    // Coprocessor 0 register numbers
    typedef enum logic [4:0] {
        INDEX     = 5'd0,
        RANDOM    = 5'd1,
        ENTRY_LO0 = 5'd2,
        ENTRY_LO1 = 5'd3,
        WIRED     = 5'd6,
        COUNT     = 5'd9,
        ENTRY_HI  = 5'd10,
        COMPARE   = 5'd11,
        STATUS    = 5'd12,
        CAUSE     = 5'd13,
        EPC       = 5'd14
    } cp0_reg_e;

    //////////////////////////////
    // Register field layouts
    //////////////////////////////

    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  im;
        logic [5:0]  zero_lo;
        logic        exl;
        logic        ie;
    } status_t;

    typedef struct packed {
        logic        bd;
        logic [14:0] zero_hi;
        logic [7:0]  ip;
        logic        zero_mid;
        logic [4:0]  exc_code;
        logic [1:0]  zero_lo;
    } cause_t;

    typedef struct packed {
        logic [5:0]  zero_hi;
        logic [19:0] pfn;
        logic [2:0]  zero_lo;
        logic        d;
        logic        v;
        logic        g;
    } entry_lo_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero_mid;
        logic [7:0]  asid;
    } entry_hi_t;

    typedef struct packed {
        logic        p;
        logic [25:0] zero_mid;
        logic [4:0]  idx;
    } index_t;

    // One 32-bit word seen through each register layout
    typedef union packed {
        logic [31:0] raw;
        status_t     status;
        cause_t      cause;
        entry_lo_t   entry_lo;
        entry_hi_t   entry_hi;
        index_t      index;
    } cp0_word_u;

    // Write enables, one per writable register
    typedef struct packed {
        logic index;
        logic entry_lo0;
        logic entry_lo1;
        logic wired;
        logic count;
        logic entry_hi;
        logic compare;
        logic status;
        logic cause;
        logic epc;
    } cp0_we_t;

endpackage

// ==== rtl/cp0_exc_pkg.sv ====
package cp0_exc_pkg;

    import cp0_reg_pkg::*;

    // ExcCode values as stored in Cause
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_e;

    // Exception reported by the core
    typedef struct packed {
        logic        valid;
        exc_code_e   code;
        logic        bd;
        logic [31:0] epc;
    } exc_event_t;

    // Result of a TLB probe
    typedef struct packed {
        logic       valid;
        logic       miss;
        logic [4:0] index;
    } tlb_probe_t;

    // Entry read back from the TLB array
    typedef struct packed {
        logic      valid;
        entry_lo_t lo0;
        entry_lo_t lo1;
        entry_hi_t hi;
    } tlb_read_t;

endpackage

// ==== rtl/cp0_write_decode.sv ====
`timescale 1ns/1ps

module cp0_write_decode
    import cp0_reg_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     we,
    input  cp0_reg_e reg_num,
    output cp0_we_t  wr_en
);

    // One enable per implemented writable register
    always_comb begin
        wr_en = '0;
        if (we) begin
            case (reg_num)
                INDEX:     wr_en.index     = 1'b1;
                ENTRY_LO0: wr_en.entry_lo0 = 1'b1;
                ENTRY_LO1: wr_en.entry_lo1 = 1'b1;
                WIRED:     wr_en.wired     = 1'b1;
                COUNT:     wr_en.count     = 1'b1;
                ENTRY_HI:  wr_en.entry_hi  = 1'b1;
                COMPARE:   wr_en.compare   = 1'b1;
                STATUS:    wr_en.status    = 1'b1;
                CAUSE:     wr_en.cause     = 1'b1;
                EPC:       wr_en.epc       = 1'b1;
                // Random and unimplemented numbers drop the write
                default: ;
            endcase
        end
    end

    // Never more than one register written per cycle
    wr_en_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(wr_en)
    ) else $error("cp0: more than one write enable active");

endmodule

// ==== rtl/cp0_tlb_regs.sv ====
`timescale 1ns/1ps

module cp0_tlb_regs
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;
#(
    parameter int TLB_ENTRIES = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  cp0_we_t     wr_en,
    input  cp0_word_u   write_data,
    input  tlb_probe_t  tlb_probe,
    input  tlb_read_t   tlb_read,
    output logic [31:0] index,
    output logic [31:0] random,
    output logic [31:0] wired,
    output entry_lo_t   entry_lo0,
    output entry_lo_t   entry_lo1,
    output entry_hi_t   entry_hi
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam logic [IDX_W-1:0] TOP_ENTRY = IDX_W'(TLB_ENTRIES - 1);

    logic             index_p;
    logic [IDX_W-1:0] index_idx;
    logic [IDX_W-1:0] random_q;
    logic [IDX_W-1:0] wired_q;
    entry_lo_t        entry_lo0_q;
    entry_lo_t        entry_lo1_q;
    entry_hi_t        entry_hi_q;
    index_t           index_word;

    // Keep only the implemented EntryLo fields
    function automatic entry_lo_t clean_lo(entry_lo_t lo);
        entry_lo_t res;
        res     = '0;
        res.pfn = lo.pfn;
        res.d   = lo.d;
        res.v   = lo.v;
        res.g   = lo.g;
        return res;
    endfunction

    function automatic entry_hi_t clean_hi(entry_hi_t hi);
        entry_hi_t res;
        res      = '0;
        res.vpn2 = hi.vpn2;
        res.asid = hi.asid;
        return res;
    endfunction

    //////////////////////////////
    // Index, probe has priority
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index_p   <= 1'b0;
            index_idx <= '0;
        end else if (tlb_probe.valid) begin
            index_p   <= tlb_probe.miss;
            index_idx <= tlb_probe.index[IDX_W-1:0];
        end else if (wr_en.index) begin
            // Software sets the index field only, P is kept
            index_idx <= write_data.index.idx[IDX_W-1:0];
        end
    end

    // EntryLo0/1 and EntryHi, TLB read has priority
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_lo0_q <= '0;
            entry_lo1_q <= '0;
            entry_hi_q  <= '0;
        end else if (tlb_read.valid) begin
            entry_lo0_q <= clean_lo(tlb_read.lo0);
            entry_lo1_q <= clean_lo(tlb_read.lo1);
            entry_hi_q  <= clean_hi(tlb_read.hi);
        end else begin
            if (wr_en.entry_lo0)
                entry_lo0_q <= clean_lo(write_data.entry_lo);
            if (wr_en.entry_lo1)
                entry_lo1_q <= clean_lo(write_data.entry_lo);
            if (wr_en.entry_hi)
                entry_hi_q <= clean_hi(write_data.entry_hi);
        end
    end

    //////////////////////////////
    // Random countdown over the unwired entries
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wired_q  <= '0;
            random_q <= TOP_ENTRY;
        end else if (wr_en.wired) begin
            wired_q  <= write_data.raw[IDX_W-1:0];
            random_q <= TOP_ENTRY;
        end else if (random_q == wired_q) begin
            random_q <= TOP_ENTRY;
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    always_comb begin
        index_word     = '0;
        index_word.p   = index_p;
        index_word.idx = 5'(index_idx);
    end

    assign index     = index_word;
    assign random    = 32'(random_q);
    assign wired     = 32'(wired_q);
    assign entry_lo0 = entry_lo0_q;
    assign entry_lo1 = entry_lo1_q;
    assign entry_hi  = entry_hi_q;

    random_above_wired: assert property (
        @(posedge clk) disable iff (!arst_n)
        $stable(wired_q) |-> (random_q >= wired_q)
    ) else $error("cp0: Random fell below Wired");

endmodule

// ==== rtl/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer
    import cp0_reg_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  cp0_we_t     wr_en,
    input  logic [31:0] write_data,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        timer_int_q;
    logic        match;

    assign match = (count_q == compare_q);

    // Free running counter, a write replaces it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            count_q <= '0;
        else if (wr_en.count)
            count_q <= write_data;
        else
            count_q <= count_q + 32'd1;
    end

    // All ones at reset keeps the match away early on
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            compare_q <= '1;
        else if (wr_en.compare)
            compare_q <= write_data;
    end

    // Sticky until software writes Compare
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            timer_int_q <= 1'b0;
        else if (wr_en.compare)
            timer_int_q <= 1'b0;
        else if (match)
            timer_int_q <= 1'b1;
    end

    assign count     = count_q;
    assign compare   = compare_q;
    assign timer_int = timer_int_q;

endmodule

// ==== rtl/cp0_exc_regs.sv ====
`timescale 1ns/1ps

module cp0_exc_regs
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  cp0_we_t     wr_en,
    input  cp0_word_u   write_data,
    input  exc_event_t  exc,
    input  logic        eret,
    input  logic [5:0]  hip,
    input  logic        timer_int,
    output status_t     status,
    output cause_t      cause,
    output logic [31:0] epc,
    output logic        irq
);

    status_t     status_q;
    status_t     status_wr;
    logic        bd_q;
    exc_code_e   code_q;
    logic [1:0]  sw_ip_q;
    logic [31:0] epc_q;

    // Writable Status bits
    always_comb begin
        status_wr     = '0;
        status_wr.ie  = write_data.status.ie;
        status_wr.exl = write_data.status.exl;
        status_wr.im  = write_data.status.im;
    end

    //////////////////////////////
    // Exception entry and return
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            status_q <= '0;
        else if (exc.valid)
            status_q.exl <= 1'b1;
        else if (eret)
            status_q.exl <= 1'b0;
        else if (wr_en.status)
            status_q <= status_wr;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bd_q    <= 1'b0;
            code_q  <= INT;
            sw_ip_q <= '0;
            epc_q   <= '0;
        end else if (exc.valid) begin
            bd_q   <= exc.bd;
            code_q <= exc.code;
            epc_q  <= exc.epc;
        end else begin
            // Cause write reaches the software IP bits only
            if (wr_en.cause)
                sw_ip_q <= write_data.cause.ip[1:0];
            if (wr_en.epc)
                epc_q <= write_data.raw;
        end
    end

    // Hardware pending bits track the pins, timer shares IP7
    always_comb begin
        cause          = '0;
        cause.bd       = bd_q;
        cause.ip       = {hip[5] | timer_int, hip[4:0], sw_ip_q};
        cause.exc_code = code_q;
    end

    assign status = status_q;
    assign epc    = epc_q;
    assign irq    = status_q.ie & ~status_q.exl & (|(status_q.im & cause.ip));

    // Core never retires an exception and an ERET in one cycle
    exc_eret_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(exc.valid && eret)
    ) else $error("cp0: exception and eret in the same cycle");

endmodule

// ==== rtl/cp0_read_mux.sv ====
`timescale 1ns/1ps

module cp0_read_mux
    import cp0_reg_pkg::*;
(
    input  cp0_reg_e    reg_num,
    input  logic [31:0] index,
    input  logic [31:0] random,
    input  logic [31:0] wired,
    input  entry_lo_t   entry_lo0,
    input  entry_lo_t   entry_lo1,
    input  entry_hi_t   entry_hi,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  status_t     status,
    input  cause_t      cause,
    input  logic [31:0] epc,
    output logic [31:0] read_data
);

    always_comb begin
        case (reg_num)
            INDEX:     read_data = index;
            RANDOM:    read_data = random;
            ENTRY_LO0: read_data = entry_lo0;
            ENTRY_LO1: read_data = entry_lo1;
            WIRED:     read_data = wired;
            COUNT:     read_data = count;
            ENTRY_HI:  read_data = entry_hi;
            COMPARE:   read_data = compare;
            STATUS:    read_data = status;
            CAUSE:     read_data = cause;
            EPC:       read_data = epc;
            // Unimplemented numbers
            default:   read_data = '0;
        endcase
    end

endmodule

// ==== rtl/cp0.sv ====
`timescale 1ns/1ps

module cp0
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;
#(
    parameter int TLB_ENTRIES = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  cp0_reg_e    reg_num,
    input  cp0_word_u   write_data,
    input  exc_event_t  exc,
    input  logic        eret,
    input  logic [5:0]  hip,
    input  tlb_probe_t  tlb_probe,
    input  tlb_read_t   tlb_read,
    output logic [31:0] read_data,
    output status_t     status,
    output cause_t      cause,
    output logic [31:0] epc,
    output entry_lo_t   entry_lo0,
    output entry_lo_t   entry_lo1,
    output entry_hi_t   entry_hi,
    output logic [31:0] index,
    output logic        timer_int,
    output logic        irq
);

    cp0_we_t     wr_en;
    logic [31:0] random;
    logic [31:0] wired;
    logic [31:0] count;
    logic [31:0] compare;

    //////////////////////////////
    // Write side
    //////////////////////////////
    cp0_write_decode i_write_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (we),
        .reg_num (reg_num),
        .wr_en   (wr_en)
    );

    //////////////////////////////
    // Register blocks
    //////////////////////////////
    cp0_tlb_regs #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .write_data (write_data),
        .tlb_probe  (tlb_probe),
        .tlb_read   (tlb_read),
        .index      (index),
        .random     (random),
        .wired      (wired),
        .entry_lo0  (entry_lo0),
        .entry_lo1  (entry_lo1),
        .entry_hi   (entry_hi)
    );

    cp0_timer i_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .write_data (write_data.raw),
        .count      (count),
        .compare    (compare),
        .timer_int  (timer_int)
    );

    cp0_exc_regs i_exc_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .write_data (write_data),
        .exc        (exc),
        .eret       (eret),
        .hip        (hip),
        .timer_int  (timer_int),
        .status     (status),
        .cause      (cause),
        .epc        (epc),
        .irq        (irq)
    );

    // Read side
    cp0_read_mux i_read_mux (
        .reg_num   (reg_num),
        .index     (index),
        .random    (random),
        .wired     (wired),
        .entry_lo0 (entry_lo0),
        .entry_lo1 (entry_lo1),
        .entry_hi  (entry_hi),
        .count     (count),
        .compare   (compare),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .read_data (read_data)
    );

endmodule

// ==== testbench/cp0_tb.sv ====
`timescale 1ns/1ps

module cp0_tb
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;
();

    localparam int TLB_ENTRIES   = 16;
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int RW_CYCLES     = 200;
    localparam int RANDOM_CYCLES = 200;
    localparam int TIMER_ROUNDS  = 8;
    localparam int EXC_CYCLES    = 300;
    localparam int IRQ_CYCLES    = 300;
    localparam int TLB_CYCLES    = 300;
    // A timer round is at most 14 cycles
    localparam int TOTAL_CYCLES  = RW_CYCLES + RANDOM_CYCLES + TIMER_ROUNDS * 14
                                 + EXC_CYCLES + IRQ_CYCLES + TLB_CYCLES;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + TOTAL_CYCLES + 200) * CLK_PERIOD;

    localparam logic [31:0] IDX_MASK    = TLB_ENTRIES - 1;
    localparam logic [31:0] TOP_ENTRY   = TLB_ENTRIES - 1;
    localparam logic [31:0] LO_MASK     = 32'h03ff_ffc7;
    localparam logic [31:0] HI_MASK     = 32'hffff_e0ff;
    localparam logic [31:0] STATUS_MASK = 32'h0000_ff03;

    logic        clk;
    logic        arst_n;
    logic        we;
    cp0_reg_e    reg_num;
    cp0_word_u   write_data;
    exc_event_t  exc;
    logic        eret;
    logic [5:0]  hip;
    tlb_probe_t  tlb_probe;
    tlb_read_t   tlb_read;
    logic [31:0] read_data;
    status_t     status;
    cause_t      cause;
    logic [31:0] epc;
    entry_lo_t   entry_lo0;
    entry_lo_t   entry_lo1;
    entry_hi_t   entry_hi;
    logic [31:0] index;
    logic        timer_int;
    logic        irq;

    // Reference model state
    logic        m_index_p;
    logic [31:0] m_index_idx;
    logic [31:0] m_random;
    logic [31:0] m_wired;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_tint;
    entry_lo_t   m_lo0;
    entry_lo_t   m_lo1;
    entry_hi_t   m_hi;
    status_t     m_status;
    logic        m_bd;
    exc_code_e   m_code;
    logic [1:0]  m_swip;
    logic [31:0] m_epc;

    string cur_test;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    cp0 #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_cp0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .we         (we),
        .reg_num    (reg_num),
        .write_data (write_data),
        .exc        (exc),
        .eret       (eret),
        .hip        (hip),
        .tlb_probe  (tlb_probe),
        .tlb_read   (tlb_read),
        .read_data  (read_data),
        .status     (status),
        .cause      (cause),
        .epc        (epc),
        .entry_lo0  (entry_lo0),
        .entry_lo1  (entry_lo1),
        .entry_hi   (entry_hi),
        .index      (index),
        .timer_int  (timer_int),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic writes(cp0_reg_e r);
        return we && (reg_num == r);
    endfunction

    function automatic cause_t model_cause();
        cause_t c;
        c          = '0;
        c.bd       = m_bd;
        c.ip       = {hip[5] | m_tint, hip[4:0], m_swip};
        c.exc_code = m_code;
        return c;
    endfunction

    function automatic index_t model_index();
        index_t i;
        i     = '0;
        i.p   = m_index_p;
        i.idx = m_index_idx[4:0];
        return i;
    endfunction

    function automatic logic model_irq();
        cause_t c;
        c = model_cause();
        return m_status.ie && !m_status.exl && ((m_status.im & c.ip) != 8'd0);
    endfunction

    function automatic logic [31:0] model_read(cp0_reg_e r);
        case (r)
            INDEX:     return model_index();
            RANDOM:    return m_random;
            ENTRY_LO0: return m_lo0;
            ENTRY_LO1: return m_lo1;
            WIRED:     return m_wired;
            COUNT:     return m_count;
            ENTRY_HI:  return m_hi;
            COMPARE:   return m_compare;
            STATUS:    return m_status;
            CAUSE:     return model_cause();
            EPC:       return m_epc;
            default:   return 32'd0;
        endcase
    endfunction

    task automatic model_reset();
        m_index_p   = 1'b0;
        m_index_idx = '0;
        m_random    = TOP_ENTRY;
        m_wired     = '0;
        m_count     = '0;
        m_compare   = '1;
        m_tint      = 1'b0;
        m_lo0       = '0;
        m_lo1       = '0;
        m_hi        = '0;
        m_status    = '0;
        m_bd        = 1'b0;
        m_code      = INT;
        m_swip      = '0;
        m_epc       = '0;
    endtask

    // Advances the model by one clock edge with the inputs now driven
    task automatic model_step();
        // Match uses Count and Compare before the edge
        if (writes(COMPARE))
            m_tint = 1'b0;
        else if (m_count == m_compare)
            m_tint = 1'b1;
        m_count = writes(COUNT) ? write_data.raw : m_count + 32'd1;
        if (writes(COMPARE))
            m_compare = write_data.raw;

        if (writes(WIRED)) begin
            m_wired  = write_data.raw & IDX_MASK;
            m_random = TOP_ENTRY;
        end else if (m_random == m_wired) begin
            m_random = TOP_ENTRY;
        end else begin
            m_random = m_random - 32'd1;
        end

        if (tlb_probe.valid) begin
            m_index_p   = tlb_probe.miss;
            m_index_idx = 32'(tlb_probe.index) & IDX_MASK;
        end else if (writes(INDEX)) begin
            m_index_idx = write_data.raw & IDX_MASK;
        end

        if (tlb_read.valid) begin
            m_lo0 = tlb_read.lo0 & LO_MASK;
            m_lo1 = tlb_read.lo1 & LO_MASK;
            m_hi  = tlb_read.hi & HI_MASK;
        end else begin
            if (writes(ENTRY_LO0))
                m_lo0 = write_data.raw & LO_MASK;
            if (writes(ENTRY_LO1))
                m_lo1 = write_data.raw & LO_MASK;
            if (writes(ENTRY_HI))
                m_hi = write_data.raw & HI_MASK;
        end

        if (exc.valid)
            m_status.exl = 1'b1;
        else if (eret)
            m_status.exl = 1'b0;
        else if (writes(STATUS))
            m_status = write_data.raw & STATUS_MASK;

        if (exc.valid) begin
            m_bd   = exc.bd;
            m_code = exc.code;
            m_epc  = exc.epc;
        end else begin
            if (writes(CAUSE))
                m_swip = write_data.raw[9:8];
            if (writes(EPC))
                m_epc = write_data.raw;
        end
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_word(input string what, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errors++;
            $display("CHECK FAILED %s %s: expected %08h, actual %08h",
                     cur_test, what, exp_val, act_val);
        end
    endtask

    task automatic check_status(input string what, input status_t exp_val,
                                input status_t act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errors++;
            $display("CHECK FAILED %s %s: expected %08h, actual %08h",
                     cur_test, what, exp_val, act_val);
        end
    endtask

    task automatic check_cause(input string what, input cause_t exp_val,
                               input cause_t act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errors++;
            $display("CHECK FAILED %s %s: expected %08h, actual %08h",
                     cur_test, what, exp_val, act_val);
        end
    endtask

    task automatic check_entry(input string what, input entry_lo_t exp_val,
                               input entry_lo_t act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errors++;
            $display("CHECK FAILED %s %s: expected %08h, actual %08h",
                     cur_test, what, exp_val, act_val);
        end
    endtask

    task automatic check_outputs();
        check_word("read_data", model_read(reg_num), read_data);
        check_status("status", m_status, status);
        check_cause("cause", model_cause(), cause);
        check_word("epc", m_epc, epc);
        check_entry("entry_lo0", m_lo0, entry_lo0);
        check_entry("entry_lo1", m_lo1, entry_lo1);
        check_word("entry_hi", m_hi, entry_hi);
        check_word("index", model_index(), index);
        check_word("timer_int", 32'(m_tint), 32'(timer_int));
        check_word("irq", 32'(model_irq()), 32'(irq));
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic clear_inputs();
        we         = 1'b0;
        write_data = '0;
        exc        = '0;
        eret       = 1'b0;
        tlb_probe  = '0;
        tlb_read   = '0;
    endtask

    function automatic exc_code_e pick_code();
        case ($urandom % 10)
            0:       return INT;
            1:       return MOD;
            2:       return TLBL;
            3:       return TLBS;
            4:       return ADEL;
            5:       return ADES;
            6:       return SYS;
            7:       return BP;
            8:       return RI;
            default: return OV;
        endcase
    endfunction

    task automatic raise_exception();
        exc.valid = 1'b1;
        exc.code  = pick_code();
        exc.bd    = 1'($urandom);
        exc.epc   = $urandom;
    endtask

    // Inputs were driven on the falling edge, results are checked one cycle on
    task automatic run_cycle();
        model_step();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        if (test_errors != 0)
            tests_failed++;
        $display("test %-10s %0d checks, %0d mismatches", cur_test, test_checks, test_errors);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_readback();
        start_test("readback");
        repeat (RW_CYCLES) begin
            clear_inputs();
            we             = ($urandom % 4) != 0;
            reg_num        = cp0_reg_e'(5'($urandom));
            write_data.raw = $urandom;
            run_cycle();
        end
        end_test();
    endtask

    task automatic test_random();
        start_test("random");
        repeat (RANDOM_CYCLES) begin
            clear_inputs();
            reg_num = RANDOM;
            case ($urandom % 8)
                0: begin
                    we             = 1'b1;
                    reg_num        = WIRED;
                    write_data.raw = $urandom % TLB_ENTRIES;
                end
                // Random itself is read only
                1: begin
                    we             = 1'b1;
                    write_data.raw = $urandom;
                end
                default: ;
            endcase
            run_cycle();
        end
        end_test();
    endtask

    task automatic test_timer();
        int gap;
        start_test("timer");
        repeat (TIMER_ROUNDS) begin
            clear_inputs();
            we             = 1'b1;
            reg_num        = COUNT;
            write_data.raw = $urandom;
            run_cycle();
            gap = 2 + ($urandom % 8);
            clear_inputs();
            we             = 1'b1;
            reg_num        = COMPARE;
            write_data.raw = m_count + 32'(gap);
            run_cycle();
            repeat (gap + 1) begin
                clear_inputs();
                reg_num = COUNT;
                run_cycle();
            end
            check_word("timer_int raised", 32'd1, 32'(timer_int));
            clear_inputs();
            we             = 1'b1;
            reg_num        = COMPARE;
            write_data.raw = $urandom;
            run_cycle();
            check_word("timer_int cleared", 32'd0, 32'(timer_int));
        end
        end_test();
    endtask

    task automatic test_exceptions();
        cp0_reg_e targets [3] = '{STATUS, CAUSE, EPC};
        start_test("exceptions");
        repeat (EXC_CYCLES) begin
            clear_inputs();
            hip     = 6'($urandom);
            reg_num = targets[$urandom % 3];
            case ($urandom % 4)
                0:       raise_exception();
                1:       eret = 1'b1;
                default: ;
            endcase
            we             = 1'($urandom);
            write_data.raw = $urandom;
            run_cycle();
        end
        end_test();
    endtask

    task automatic test_interrupts();
        cp0_reg_e targets [2] = '{STATUS, CAUSE};
        start_test("interrupts");
        repeat (IRQ_CYCLES) begin
            clear_inputs();
            hip     = 6'($urandom);
            reg_num = targets[$urandom % 2];
            case ($urandom % 8)
                0:       raise_exception();
                1:       eret = 1'b1;
                default: ;
            endcase
            we             = 1'($urandom);
            write_data.raw = $urandom;
            run_cycle();
        end
        end_test();
    endtask

    task automatic test_tlb();
        cp0_reg_e targets [5] = '{INDEX, ENTRY_LO0, ENTRY_LO1, ENTRY_HI, WIRED};
        start_test("tlb");
        repeat (TLB_CYCLES) begin
            clear_inputs();
            reg_num = targets[$urandom % 5];
            if (($urandom % 4) == 0) begin
                tlb_probe.valid = 1'b1;
                tlb_probe.miss  = 1'($urandom);
                tlb_probe.index = 5'($urandom);
            end
            if (($urandom % 4) == 0) begin
                tlb_read.valid = 1'b1;
                tlb_read.lo0   = $urandom;
                tlb_read.lo1   = $urandom;
                tlb_read.hi    = $urandom;
            end
            we             = 1'($urandom);
            write_data.raw = $urandom;
            run_cycle();
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'he9ce83f5));
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        reg_num      = INDEX;
        hip          = '0;
        clear_inputs();
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("reset");
        check_outputs();
        end_test();

        test_readback();
        test_random();
        test_timer();
        test_exceptions();
        test_interrupts();
        test_tlb();

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/cp0_reg_pkg.sv
rtl/cp0_exc_pkg.sv
rtl/cp0_write_decode.sv
rtl/cp0_tlb_regs.sv
rtl/cp0_timer.sv
rtl/cp0_exc_regs.sv
rtl/cp0_read_mux.sv
rtl/cp0.sv
testbench/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0

sources:
  # Packages first, the register package is imported by the exception package
  - rtl/cp0_reg_pkg.sv
  - rtl/cp0_exc_pkg.sv
  - rtl/cp0_write_decode.sv
  - rtl/cp0_tlb_regs.sv
  - rtl/cp0_timer.sv
  - rtl/cp0_exc_regs.sv
  - rtl/cp0_read_mux.sv
  - rtl/cp0.sv
  - target: simulation
    files:
      - testbench/cp0_tb.sv
